/* design/id_pkg.sv */
`default_nettype none

package id_pkg;

  // ------------------------------------------------------------------------
  // Fetch and issue entries
  // ------------------------------------------------------------------------

  // Entry handed over by the fetch stage
  typedef struct packed {
    logic [31:0] address;
    logic [31:0] instruction;
    logic        fetch_fault;
  } fetch_entry_t;

  // Functional unit that executes the instruction
  typedef enum logic [1:0] {
    FU_NONE,
    FU_ALU,
    FU_LSU,
    FU_BRANCH
  } fu_e;

  // Operation inside the selected unit
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_SLT,
    OP_LW, OP_SW,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
    OP_JAL, OP_JALR, OP_LUI
  } fu_op_e;

  // Decoded entry toward issue, exception info rides along
  typedef struct packed {
    logic [31:0] pc;
    fu_e         fu;
    fu_op_e      op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        use_imm;
    logic        is_compressed;
    logic        ex_valid;
    logic        ex_is_irq;
    logic [3:0]  ex_cause;
  } issue_entry_t;

  // Pending interrupt after masking and priority
  typedef struct packed {
    logic       valid;
    logic [3:0] cause;
  } irq_req_t;

  // ------------------------------------------------------------------------
  // Major opcodes of the RV32I subset
  // ------------------------------------------------------------------------
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // Exception and interrupt causes
  localparam logic [3:0] CAUSE_FETCH_FAULT = 4'd1;
  localparam logic [3:0] CAUSE_ILLEGAL     = 4'd2;
  localparam logic [3:0] CAUSE_M_TIMER     = 4'd7;
  localparam logic [3:0] CAUSE_M_EXT       = 4'd11;

endpackage

`default_nettype wire

/* design/rvc_expander.sv */
`timescale 1ns/1ns
`default_nettype none

module rvc_expander #(
  parameter bit RVC = 1'b1
) (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        illegal_o,
  output logic        is_compressed_o
);
  import id_pkg::*;

  logic [1:0] quadrant;
  logic [2:0] funct3;
  logic [4:0] rd_full;
  logic [4:0] rs2_full;
  logic [4:0] rs1_prime;

  // Compressed field slices
  assign quadrant  = instr_i[1:0];
  assign funct3    = instr_i[15:13];
  assign rd_full   = instr_i[11:7];
  assign rs2_full  = instr_i[6:2];
  // Three-bit register fields address x8 to x15
  assign rs1_prime = {2'b01, instr_i[9:7]};

  // Any quadrant other than 11 is a 16-bit word
  assign is_compressed_o = (quadrant != 2'b11);

  // ------------------------------------------------------------------------
  // Expansion into base encodings
  // ------------------------------------------------------------------------
  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;
    if (is_compressed_o) begin
      // Illegal unless one of the supported forms matches below
      illegal_o = 1'b1;
      if (RVC) begin
        case ({quadrant, funct3})
          // C.ADDI and C.NOP -> addi rd, rd, imm
          5'b01_000: begin
            instr_o   = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], rd_full, 3'b000,
                         rd_full, OPC_OP_IMM};
            illegal_o = 1'b0;
          end
          // C.LI -> addi rd, x0, imm
          5'b01_010: begin
            instr_o   = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'd0, 3'b000,
                         rd_full, OPC_OP_IMM};
            illegal_o = 1'b0;
          end
          // C.J -> jal x0, offset
          5'b01_101: begin
            instr_o   = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                         instr_i[2], instr_i[11], instr_i[5:3], instr_i[12],
                         {8{instr_i[12]}}, 5'd0, OPC_JAL};
            illegal_o = 1'b0;
          end
          // C.BEQZ -> beq rs1', x0, offset
          5'b01_110: begin
            instr_o   = {instr_i[12], {3{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'd0,
                         rs1_prime, 3'b000, instr_i[11:10], instr_i[4:3], instr_i[12],
                         OPC_BRANCH};
            illegal_o = 1'b0;
          end
          // C.MV and C.ADD; rs2 of zero would be C.JR or C.JALR
          5'b10_100: begin
            if (rs2_full != 5'd0) begin
              if (instr_i[12]) begin
                instr_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, OPC_OP};
              end else begin
                instr_o = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, OPC_OP};
              end
              illegal_o = 1'b0;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // A full-width word is never flagged here
  always_comb begin
    assert (!(illegal_o && !is_compressed_o))
      else $error("rvc_expander: illegal flag on 32-bit word %h", instr_i);
  end

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  logic [31:0]          instr_i,
  input  logic [31:0]          pc_i,
  input  logic                 is_compressed_i,
  input  logic                 illegal_i,
  input  logic                 fetch_fault_i,
  output id_pkg::issue_entry_t entry_o
);
  import id_pkg::*;

  // Immediate format of the current word
  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_sel_e;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i_type;
  logic [31:0] imm_s_type;
  logic [31:0] imm_b_type;
  logic [31:0] imm_u_type;
  logic [31:0] imm_j_type;
  imm_sel_e    imm_sel;
  logic        legal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // ------------------------------------------------------------------------
  // Immediates, all sign extended from bit 31
  // ------------------------------------------------------------------------
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb begin
    entry_o               = '0;
    entry_o.pc            = pc_i;
    entry_o.is_compressed = is_compressed_i;
    imm_sel               = IMM_NONE;
    legal                 = 1'b0;

    case (opcode)
      OPC_LUI: begin
        legal = 1'b1; entry_o.fu = FU_ALU; entry_o.op = OP_LUI;
        entry_o.rd = instr_i[11:7]; entry_o.use_imm = 1'b1; imm_sel = IMM_U;
      end
      OPC_JAL: begin
        legal = 1'b1; entry_o.fu = FU_BRANCH; entry_o.op = OP_JAL;
        entry_o.rd = instr_i[11:7]; entry_o.use_imm = 1'b1; imm_sel = IMM_J;
      end
      OPC_JALR: begin
        legal = (funct3 == 3'b000); entry_o.fu = FU_BRANCH; entry_o.op = OP_JALR;
        entry_o.rd = instr_i[11:7]; entry_o.rs1 = instr_i[19:15];
        entry_o.use_imm = 1'b1; imm_sel = IMM_I;
      end
      // Compare rs1 with rs2, the offset only feeds the target adder
      OPC_BRANCH: begin
        legal = 1'b1; entry_o.fu = FU_BRANCH; imm_sel = IMM_B;
        entry_o.rs1 = instr_i[19:15]; entry_o.rs2 = instr_i[24:20];
        case (funct3)
          3'b000:  entry_o.op = OP_BEQ;
          3'b001:  entry_o.op = OP_BNE;
          3'b100:  entry_o.op = OP_BLT;
          3'b101:  entry_o.op = OP_BGE;
          default: legal = 1'b0;
        endcase
      end
      OPC_LOAD: begin
        legal = (funct3 == 3'b010); entry_o.fu = FU_LSU; entry_o.op = OP_LW;
        entry_o.rd = instr_i[11:7]; entry_o.rs1 = instr_i[19:15];
        entry_o.use_imm = 1'b1; imm_sel = IMM_I;
      end
      OPC_STORE: begin
        legal = (funct3 == 3'b010); entry_o.fu = FU_LSU; entry_o.op = OP_SW;
        entry_o.rs1 = instr_i[19:15]; entry_o.rs2 = instr_i[24:20];
        entry_o.use_imm = 1'b1; imm_sel = IMM_S;
      end
      OPC_OP_IMM: begin
        legal = 1'b1; entry_o.fu = FU_ALU; imm_sel = IMM_I; entry_o.use_imm = 1'b1;
        entry_o.rd = instr_i[11:7]; entry_o.rs1 = instr_i[19:15];
        case (funct3)
          3'b000:  entry_o.op = OP_ADD;
          3'b010:  entry_o.op = OP_SLT;
          3'b100:  entry_o.op = OP_XOR;
          3'b110:  entry_o.op = OP_OR;
          3'b111:  entry_o.op = OP_AND;
          3'b001: begin
            entry_o.op = OP_SLL;
            legal      = (funct7 == 7'b0);
          end
          // Bit 30 picks arithmetic shift
          3'b101: begin
            entry_o.op = funct7[5] ? OP_SRA : OP_SRL;
            legal      = ({funct7[6], funct7[4:0]} == 6'b0);
          end
          default: legal = 1'b0;
        endcase
      end
      OPC_OP: begin
        legal = 1'b1; entry_o.fu = FU_ALU;
        entry_o.rd = instr_i[11:7]; entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        case ({funct7, funct3})
          10'b0000000_000: entry_o.op = OP_ADD;
          10'b0100000_000: entry_o.op = OP_SUB;
          10'b0000000_111: entry_o.op = OP_AND;
          10'b0000000_110: entry_o.op = OP_OR;
          10'b0000000_100: entry_o.op = OP_XOR;
          10'b0000000_001: entry_o.op = OP_SLL;
          10'b0000000_101: entry_o.op = OP_SRL;
          10'b0100000_101: entry_o.op = OP_SRA;
          10'b0000000_010: entry_o.op = OP_SLT;
          default:         legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase

    case (imm_sel)
      IMM_I:   entry_o.imm = imm_i_type;
      IMM_S:   entry_o.imm = imm_s_type;
      IMM_B:   entry_o.imm = imm_b_type;
      IMM_U:   entry_o.imm = imm_u_type;
      IMM_J:   entry_o.imm = imm_j_type;
      default: entry_o.imm = '0;
    endcase

    // Faulting entries keep only pc and format, fetch fault wins
    if (fetch_fault_i || illegal_i || !legal) begin
      entry_o.fu       = FU_NONE;
      entry_o.op       = OP_ADD;
      entry_o.rs1      = '0;
      entry_o.rs2      = '0;
      entry_o.rd       = '0;
      entry_o.imm      = '0;
      entry_o.use_imm  = 1'b0;
      entry_o.ex_valid = 1'b1;
      entry_o.ex_cause = fetch_fault_i ? CAUSE_FETCH_FAULT : CAUSE_ILLEGAL;
    end
  end

  // Issue relies on a cause whenever the exception flag is up
  always_comb begin
    if (entry_o.ex_valid) begin
      assert (entry_o.ex_cause != 4'd0)
        else $error("instr_decoder: exception without cause at pc %h", pc_i);
    end
  end

endmodule

`default_nettype wire

/* design/irq_selector.sv */
`timescale 1ns/1ns
`default_nettype none

module irq_selector (
  input  logic [1:0]       irq_i,
  input  logic             irq_en_i,
  output id_pkg::irq_req_t irq_o
);
  import id_pkg::*;

  // Bit 0 machine timer, bit 1 machine external
  logic [1:0] irq_masked;

  // Global enable from the CSR side gates every line
  assign irq_masked = irq_i & {2{irq_en_i}};

  // ------------------------------------------------------------------------
  // Fixed priority, external over timer
  // ------------------------------------------------------------------------
  always_comb begin
    irq_o = '0;
    if (irq_masked[1]) begin
      irq_o.valid = 1'b1;
      irq_o.cause = CAUSE_M_EXT;
    end else if (irq_masked[0]) begin
      irq_o.valid = 1'b1;
      irq_o.cause = CAUSE_M_TIMER;
    end
  end

endmodule

`default_nettype wire

/* design/issue_register.sv */
`timescale 1ns/1ns
`default_nettype none

module issue_register (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  id_pkg::issue_entry_t decoded_i,
  input  id_pkg::irq_req_t     irq_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  logic                 issue_ack_i,
  input  logic                 flush_i,
  output id_pkg::issue_entry_t issue_entry_o,
  output logic                 issue_valid_o
);
  import id_pkg::*;

  // Single slot between decode and issue
  typedef struct packed {
    logic         valid;
    issue_entry_t entry;
  } issue_slot_t;

  issue_slot_t  slot_d;
  issue_slot_t  slot_q;
  issue_entry_t merged;

  // Pending interrupt rides on the accepted entry
  always_comb begin
    merged = decoded_i;
    if (irq_i.valid) begin
      merged.ex_valid  = 1'b1;
      merged.ex_is_irq = 1'b1;
      merged.ex_cause  = irq_i.cause;
    end
  end

  // ------------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------------
  always_comb begin
    slot_d        = slot_q;
    fetch_ready_o = 1'b0;
    // Issue took the entry
    if (issue_ack_i) slot_d.valid = 1'b0;
    // Room now or freed by the ack this cycle
    if ((!slot_q.valid || issue_ack_i) && fetch_valid_i) begin
      fetch_ready_o = 1'b1;
      slot_d        = '{valid: 1'b1, entry: merged};
    end
    // Flush drops whatever would be held
    if (flush_i) slot_d.valid = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q <= '0;
    end else begin
      slot_q <= slot_d;
    end
  end

  assign issue_entry_o = slot_q.entry;
  assign issue_valid_o = slot_q.valid;

  // Issue only acknowledges what it was offered
  ack_while_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> slot_q.valid)
    else $error("issue_register: ack without valid entry");

  // Held entry must not move while issue stalls
  hold_under_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slot_q.valid && !issue_ack_i |=> $stable(issue_entry_o))
    else $error("issue_register: entry changed under back-pressure");

endmodule

`default_nettype wire

/* design/id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage #(
  parameter bit RVC = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  id_pkg::fetch_entry_t fetch_entry_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  output id_pkg::issue_entry_t issue_entry_o,
  output logic                 issue_valid_o,
  input  logic                 issue_ack_i,
  input  logic [1:0]           irq_i,
  input  logic                 irq_en_i
);
  import id_pkg::*;

  logic [31:0]  instr_expanded;
  logic         rvc_illegal;
  logic         is_compressed;
  issue_entry_t decoded;
  irq_req_t     irq;

  // ------------------------------------------------------------------------
  // Instruction path, expand then decode
  // ------------------------------------------------------------------------
  rvc_expander #(
    .RVC (RVC)
  ) rvc_expander_i (
    .instr_i         (fetch_entry_i.instruction),
    .instr_o         (instr_expanded),
    .illegal_o       (rvc_illegal),
    .is_compressed_o (is_compressed)
  );

  instr_decoder instr_decoder_i (
    .instr_i         (instr_expanded),
    .pc_i            (fetch_entry_i.address),
    .is_compressed_i (is_compressed),
    .illegal_i       (rvc_illegal),
    .fetch_fault_i   (fetch_entry_i.fetch_fault),
    .entry_o         (decoded)
  );

  // Interrupt path alongside
  irq_selector irq_selector_i (
    .irq_i    (irq_i),
    .irq_en_i (irq_en_i),
    .irq_o    (irq)
  );

  // ------------------------------------------------------------------------
  // Register toward issue
  // ------------------------------------------------------------------------
  issue_register issue_register_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .decoded_i     (decoded),
    .irq_i         (irq),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_ack_i   (issue_ack_i),
    .flush_i       (flush_i),
    .issue_entry_o (issue_entry_o),
    .issue_valid_o (issue_valid_o)
  );

endmodule

`default_nettype wire

/* bench/tb_id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;
  import id_pkg::*;

  // Cycles any single wait may take
  localparam int TIMEOUT = 20;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         flush_i;
  fetch_entry_t fetch_entry_i;
  logic         fetch_valid_i;
  logic         fetch_ready_o;
  issue_entry_t issue_entry_o;
  logic         issue_valid_o;
  logic         issue_ack_i;
  logic [1:0]   irq_i;
  logic         irq_en_i;

  logic [15:0]  lfsr_q;
  logic [31:0]  pc_q;
  int           errors;
  int           checks;

  id_stage #(
    .RVC (1'b1)
  ) dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_entry_i (fetch_entry_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_entry_o (issue_entry_o),
    .issue_valid_o (issue_valid_o),
    .issue_ack_i   (issue_ack_i),
    .irq_i         (irq_i),
    .irq_en_i      (irq_en_i)
  );

  // 4 ns clock period
  always #2 clk_i = ~clk_i;

  // ------------------------------------------------------------------------
  // Random fields and encodings
  // ------------------------------------------------------------------------

  // Galois LFSR, x16 + x14 + x13 + x11 + 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 16'hB400;
    return b;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_field(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic logic [31:0] next_pc();
    pc_q = pc_q + 32'd4;
    return pc_q;
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  // SW only
  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // Quadrant 1 CI form, used by C.ADDI and C.LI
  function automatic logic [31:0] ci_word(input logic [2:0] f3, input logic [5:0] imm,
                                          input logic [4:0] rd);
    return {16'h0, f3, imm[5], rd, imm[4:0], 2'b01};
  endfunction

  // Quadrant 2 CR form, bit 12 set for C.ADD
  function automatic logic [31:0] cr_word(input logic b12, input logic [4:0] rd,
                                          input logic [4:0] rs2);
    return {16'h0, 3'b100, b12, rd, rs2, 2'b10};
  endfunction

  function automatic logic [31:0] cj_word(input logic [11:0] off);
    return {16'h0, 3'b101, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1],
            off[5], 2'b01};
  endfunction

  function automatic logic [31:0] cbeqz_word(input logic [8:0] off, input logic [2:0] rsp);
    return {16'h0, 3'b110, off[8], off[4:3], rsp, off[7:6], off[2:1], off[5], 2'b01};
  endfunction

  function automatic fetch_entry_t make_fetch(input logic [31:0] pc, input logic [31:0] w,
                                              input logic fault);
    return '{address: pc, instruction: w, fetch_fault: fault};
  endfunction

  // Expected entry of a legal instruction
  function automatic issue_entry_t make_entry(input logic [31:0] pc, input fu_e fu,
                                              input fu_op_e op, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [4:0] rd,
                                              input logic [31:0] imm, input logic use_imm,
                                              input logic is_c);
    issue_entry_t e;
    e = '0;
    e.pc = pc;
    e.fu = fu;
    e.op = op;
    e.rs1 = rs1;
    e.rs2 = rs2;
    e.rd = rd;
    e.imm = imm;
    e.use_imm = use_imm;
    e.is_compressed = is_c;
    return e;
  endfunction

  // Faulting entries carry only pc, format and cause
  function automatic issue_entry_t make_exception(input logic [31:0] pc, input logic is_c,
                                                  input logic [3:0] cause);
    issue_entry_t e;
    e = '0;
    e.pc = pc;
    e.fu = FU_NONE;
    e.op = OP_ADD;
    e.is_compressed = is_c;
    e.ex_valid = 1'b1;
    e.ex_cause = cause;
    return e;
  endfunction

  // ------------------------------------------------------------------------
  // Checks and handshakes
  // ------------------------------------------------------------------------
  task automatic check_entry(input string name, input issue_entry_t exp);
    checks++;
    if (issue_entry_o !== exp) begin
      $display("CHECK FAILED %s: expected %h actual %h", name, exp, issue_entry_o);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic send_entry(input string name, input fetch_entry_t fe);
    int   n;
    logic taken;
    n = 0;
    taken = 1'b0;
    fetch_entry_i = fe;
    fetch_valid_i = 1'b1;
    while (!taken && n < TIMEOUT) begin
      // Ready is combinational, sampled mid-cycle
      @(negedge clk_i);
      taken = fetch_ready_o;
      next_cycle();
      n++;
    end
    fetch_valid_i = 1'b0;
    if (!taken) begin
      $display("%s: fetch entry not accepted within %0d cycles", name, TIMEOUT);
      errors++;
    end
  endtask

  task automatic wait_issue_valid(input string name);
    int n;
    n = 0;
    while (!issue_valid_o && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!issue_valid_o) begin
      $display("%s: timed out waiting for issue_valid_o", name);
      errors++;
    end
  endtask

  // Ack only an offered entry
  task automatic ack_issue();
    if (issue_valid_o) begin
      issue_ack_i = 1'b1;
      next_cycle();
      issue_ack_i = 1'b0;
    end
  endtask

  task automatic decode_and_check(input string name, input fetch_entry_t fe,
                                  input issue_entry_t exp);
    send_entry(name, fe);
    wait_issue_valid(name);
    check_entry(name, exp);
    ack_issue();
  endtask

  // ------------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------------
  task automatic base_decode();
    logic [31:0]  pc;
    logic [4:0]   rd, rs1, rs2;
    logic [11:0]  imm;
    logic [12:0]  boff;
    logic [20:0]  joff;
    logic [19:0]  uimm;
    issue_entry_t exp;
    rd = 5'(rand_field(5));
    rs1 = 5'(rand_field(5));
    rs2 = 5'(rand_field(5));
    imm = 12'(rand_field(12));
    boff = {12'(rand_field(12)), 1'b0};
    joff = {20'(rand_field(20)), 1'b0};
    uimm = 20'(rand_field(20));
    pc = next_pc();
    exp = make_entry(pc, FU_ALU, OP_ADD, rs1, 5'd0, rd, {{20{imm[11]}}, imm}, 1'b1, 1'b0);
    decode_and_check("addi", make_fetch(pc, i_word(imm, rs1, 3'b000, rd, 7'b0010011), 1'b0),
                     exp);
    // Shift amount sits in rs2 position, bit 30 selects arithmetic
    pc = next_pc();
    exp = make_entry(pc, FU_ALU, OP_SRA, rs1, 5'd0, rd, {20'h0, 7'b0100000, rs2}, 1'b1,
                     1'b0);
    decode_and_check("srai", make_fetch(pc, i_word({7'b0100000, rs2}, rs1, 3'b101, rd,
                                                   7'b0010011), 1'b0), exp);
    pc = next_pc();
    exp = make_entry(pc, FU_ALU, OP_SUB, rs1, rs2, rd, 32'h0, 1'b0, 1'b0);
    decode_and_check("sub", make_fetch(pc, r_word(7'b0100000, rs2, rs1, 3'b000, rd), 1'b0),
                     exp);
    pc = next_pc();
    exp = make_entry(pc, FU_LSU, OP_LW, rs1, 5'd0, rd, {{20{imm[11]}}, imm}, 1'b1, 1'b0);
    decode_and_check("lw", make_fetch(pc, i_word(imm, rs1, 3'b010, rd, 7'b0000011), 1'b0),
                     exp);
    pc = next_pc();
    exp = make_entry(pc, FU_LSU, OP_SW, rs1, rs2, 5'd0, {{20{imm[11]}}, imm}, 1'b1, 1'b0);
    decode_and_check("sw", make_fetch(pc, s_word(imm, rs2, rs1), 1'b0), exp);
    pc = next_pc();
    exp = make_entry(pc, FU_BRANCH, OP_BNE, rs1, rs2, 5'd0, {{19{boff[12]}}, boff}, 1'b0,
                     1'b0);
    decode_and_check("bne", make_fetch(pc, b_word(boff, rs2, rs1, 3'b001), 1'b0), exp);
    pc = next_pc();
    exp = make_entry(pc, FU_BRANCH, OP_JAL, 5'd0, 5'd0, rd, {{11{joff[20]}}, joff}, 1'b1,
                     1'b0);
    decode_and_check("jal", make_fetch(pc, j_word(joff, rd), 1'b0), exp);
    pc = next_pc();
    exp = make_entry(pc, FU_ALU, OP_LUI, 5'd0, 5'd0, rd, {uimm, 12'h0}, 1'b1, 1'b0);
    decode_and_check("lui", make_fetch(pc, {uimm, rd, 7'b0110111}, 1'b0), exp);
  endtask

  task automatic compressed_decode();
    logic [31:0]  pc;
    logic [4:0]   rd, rs2;
    logic [5:0]   imm;
    logic [11:0]  joff;
    logic [8:0]   boff;
    logic [2:0]   rsp;
    issue_entry_t exp;
    rd = 5'(rand_field(5));
    // Zero rs2 would encode C.JR or C.JALR
    rs2 = {4'(rand_field(4)), 1'b1};
    imm = 6'(rand_field(6));
    joff = {11'(rand_field(11)), 1'b0};
    boff = {8'(rand_field(8)), 1'b0};
    rsp = 3'(rand_field(3));
    pc = next_pc();
    exp = make_entry(pc, FU_ALU, OP_ADD, rd, 5'd0, rd, {{26{imm[5]}}, imm}, 1'b1, 1'b1);
    decode_and_check("c.addi", make_fetch(pc, ci_word(3'b000, imm, rd), 1'b0), exp);
    pc = next_pc();
    exp = make_entry(pc, FU_ALU, OP_ADD, 5'd0, 5'd0, rd, {{26{imm[5]}}, imm}, 1'b1, 1'b1);
    decode_and_check("c.li", make_fetch(pc, ci_word(3'b010, imm, rd), 1'b0), exp);
    pc = next_pc();
    exp = make_entry(pc, FU_ALU, OP_ADD, 5'd0, rs2, rd, 32'h0, 1'b0, 1'b1);
    decode_and_check("c.mv", make_fetch(pc, cr_word(1'b0, rd, rs2), 1'b0), exp);
    pc = next_pc();
    exp = make_entry(pc, FU_ALU, OP_ADD, rd, rs2, rd, 32'h0, 1'b0, 1'b1);
    decode_and_check("c.add", make_fetch(pc, cr_word(1'b1, rd, rs2), 1'b0), exp);
    pc = next_pc();
    exp = make_entry(pc, FU_BRANCH, OP_JAL, 5'd0, 5'd0, 5'd0, {{20{joff[11]}}, joff}, 1'b1,
                     1'b1);
    decode_and_check("c.j", make_fetch(pc, cj_word(joff), 1'b0), exp);
    // rs1' maps onto x8 to x15
    pc = next_pc();
    exp = make_entry(pc, FU_BRANCH, OP_BEQ, {2'b01, rsp}, 5'd0, 5'd0,
                     {{23{boff[8]}}, boff}, 1'b0, 1'b1);
    decode_and_check("c.beqz", make_fetch(pc, cbeqz_word(boff, rsp), 1'b0), exp);
  endtask

  task automatic illegal_and_fault();
    logic [31:0] pc;
    logic [4:0]  rd;
    rd = {4'(rand_field(4)), 1'b1};
    pc = next_pc();
    decode_and_check("unknown opcode", make_fetch(pc, {25'(rand_field(25)), 7'b1111111},
                     1'b0), make_exception(pc, 1'b0, CAUSE_ILLEGAL));
    // C.LW is outside the compressed subset
    pc = next_pc();
    decode_and_check("c.lw", make_fetch(pc, 32'h0000_4000, 1'b0),
                     make_exception(pc, 1'b1, CAUSE_ILLEGAL));
    pc = next_pc();
    decode_and_check("c.jr", make_fetch(pc, cr_word(1'b0, rd, 5'd0), 1'b0),
                     make_exception(pc, 1'b1, CAUSE_ILLEGAL));
    pc = next_pc();
    decode_and_check("fault legal", make_fetch(pc, i_word(12'h7, rd, 3'b000, rd,
                     7'b0010011), 1'b1), make_exception(pc, 1'b0, CAUSE_FETCH_FAULT));
    // Fault beats illegal
    pc = next_pc();
    decode_and_check("fault illegal", make_fetch(pc, 32'hFFFF_FFFF, 1'b1),
                     make_exception(pc, 1'b0, CAUSE_FETCH_FAULT));
  endtask

  task automatic interrupt_merge();
    logic [31:0]  pc;
    logic [31:0]  w;
    issue_entry_t exp;
    w = i_word(12'h123, 5'd3, 3'b000, 5'd4, 7'b0010011);
    irq_en_i = 1'b1;
    irq_i = 2'b11;
    pc = next_pc();
    exp = make_entry(pc, FU_ALU, OP_ADD, 5'd3, 5'd0, 5'd4, 32'h123, 1'b1, 1'b0);
    exp.ex_valid = 1'b1;
    exp.ex_is_irq = 1'b1;
    exp.ex_cause = 4'd11;
    decode_and_check("irq external", make_fetch(pc, w, 1'b0), exp);
    irq_i = 2'b01;
    pc = next_pc();
    exp.pc = pc;
    exp.ex_cause = 4'd7;
    decode_and_check("irq timer", make_fetch(pc, w, 1'b0), exp);
    // Global enable low masks both lines
    irq_en_i = 1'b0;
    irq_i = 2'b11;
    pc = next_pc();
    exp = make_entry(pc, FU_ALU, OP_ADD, 5'd3, 5'd0, 5'd4, 32'h123, 1'b1, 1'b0);
    decode_and_check("irq masked", make_fetch(pc, w, 1'b0), exp);
    irq_i = 2'b00;
  endtask

  task automatic back_pressure();
    logic [31:0]  pc_a;
    logic [31:0]  pc_b;
    issue_entry_t exp_a;
    issue_entry_t exp_b;
    pc_a = next_pc();
    pc_b = next_pc();
    exp_a = make_entry(pc_a, FU_ALU, OP_XOR, 5'd1, 5'd2, 5'd5, 32'h0, 1'b0, 1'b0);
    exp_b = make_entry(pc_b, FU_ALU, OP_OR, 5'd6, 5'd7, 5'd8, 32'h0, 1'b0, 1'b0);
    send_entry("stall first", make_fetch(pc_a, r_word(7'h0, 5'd2, 5'd1, 3'b100, 5'd5), 1'b0));
    wait_issue_valid("stall first");
    fetch_entry_i = make_fetch(pc_b, r_word(7'h0, 5'd7, 5'd6, 3'b110, 5'd8), 1'b0);
    fetch_valid_i = 1'b1;
    @(negedge clk_i);
    check_bit("ready under stall", 1'b0, fetch_ready_o);
    next_cycle();
    check_bit("valid under stall", 1'b1, issue_valid_o);
    check_entry("held entry", exp_a);
    // Ack and new entry in one cycle
    issue_ack_i = 1'b1;
    @(negedge clk_i);
    check_bit("ready with ack", 1'b1, fetch_ready_o);
    next_cycle();
    issue_ack_i = 1'b0;
    fetch_valid_i = 1'b0;
    check_bit("valid after replace", 1'b1, issue_valid_o);
    check_entry("replaced entry", exp_b);
    ack_issue();
  endtask

  task automatic flush_drop();
    logic [31:0] pc;
    pc = next_pc();
    send_entry("flush held", make_fetch(pc, r_word(7'h0, 5'd1, 5'd1, 3'b000, 5'd1), 1'b0));
    wait_issue_valid("flush held");
    flush_i = 1'b1;
    next_cycle();
    flush_i = 0;
    check_bit("flush held", 1'b0, issue_valid_o);
    // Flush also drops an entry accepted in the same cycle
    fetch_entry_i = make_fetch(next_pc(), r_word(7'h0, 5'd2, 5'd2, 3'b000, 5'd2), 1'b0);
    fetch_valid_i = 1'b1;
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    fetch_valid_i = 1'b0;
    check_bit("flush over accept", 1'b0, issue_valid_o);
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin
    lfsr_q = 16'd5;
    pc_q = 32'h0000_1000;
    errors = 0;
    checks = 0;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    fetch_entry_i = '0;
    fetch_valid_i = 1'b0;
    issue_ack_i = 1'b0;
    irq_i = 2'b00;
    irq_en_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_bit("valid after reset", 1'b0, issue_valid_o);
    base_decode();
    compressed_decode();
    illegal_and_fault();
    interrupt_merge();
    back_pressure();
    flush_drop();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* id_stage.f */
design/id_pkg.sv
design/rvc_expander.sv
design/instr_decoder.sv
design/irq_selector.sv
design/issue_register.sv
design/id_stage.sv
bench/tb_id_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_id_stage -f id_stage.f \
  || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/Vtb_id_stage 2>&1)"
echo "$out"
echo "$out" | grep -q "Regression passed" && exit 0 || exit 1
